// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - source/rv_isa_pkg.sv
  - source/axi_lite_pkg.sv
  - source/cushion.sv
  - source/load_unit.sv
  - source/store_unit.sv
  - source/writeback_merge.sv
  - source/mem_stage_top.sv
  - target: simulation
    files:
      - sim/axi_lite_mem_model.sv
      - sim/tb_mem_stage.sv

// ==== compile.f ====
source/rv_isa_pkg.sv
source/axi_lite_pkg.sv
source/cushion.sv
source/load_unit.sv
source/store_unit.sv
source/writeback_merge.sv
source/mem_stage_top.sv
sim/axi_lite_mem_model.sv
sim/tb_mem_stage.sv

// ==== sim/axi_lite_mem_model.sv ====
module axi_lite_mem_model (
    input  logic                                CLK,
    input  logic                                rst,
    input  logic                                ar_valid,
    output logic                                ar_ready,
    input  logic [axi_lite_pkg::axi_addr_w-1:0] ar_addr,
    output logic                                r_valid,
    input  logic                                r_ready,
    output logic [axi_lite_pkg::axi_data_w-1:0] r_data,
    output logic [axi_lite_pkg::axi_resp_w-1:0] r_resp,
    input  logic                                aw_valid,
    output logic                                aw_ready,
    input  logic [axi_lite_pkg::axi_addr_w-1:0] aw_addr,
    input  logic                                w_valid,
    output logic                                w_ready,
    input  logic [axi_lite_pkg::axi_data_w-1:0] w_data,
    input  logic [3:0]                          w_strb,
    output logic                                b_valid,
    input  logic                                b_ready,
    output logic [axi_lite_pkg::axi_resp_w-1:0] b_resp
);

    import axi_lite_pkg::*;

    // accesses to this word answer with a slave error
    localparam logic [31:0] err_addr = 32'h0000_00f0;

    logic [31:0] mem [64];
    integer      seed;
    logic [1:0]  ar_wait;
    logic [1:0]  aw_wait;
    logic [1:0]  w_wait;
    logic        aw_got;
    logic        w_got;
    logic [31:0] aw_q;
    logic [31:0] w_q;
    logic [3:0]  strb_q;

    initial begin
        seed = 47;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0203);
        end
    end

    // read channel
    always @(posedge CLK) begin
        if (rst) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            r_data   <= '0;
            r_resp   <= resp_okay;
            ar_wait  <= 2'd1;
        end else begin
            ar_ready <= 1'b0;
            if (ar_valid && !ar_ready && !r_valid) begin
                if (ar_wait == 0) begin
                    ar_ready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1;
                end
            end
            if (ar_valid && ar_ready) begin
                r_valid <= 1'b1;
                r_data  <= mem[ar_addr[7:2]];
                r_resp  <= (ar_addr == err_addr) ? resp_slverr : resp_okay;
                ar_wait <= $random(seed);
            end
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    // write channels with aw and w accepted on their own
    always @(posedge CLK) begin
        if (rst) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            b_valid  <= 1'b0;
            b_resp   <= resp_okay;
            aw_wait  <= 2'd1;
            w_wait   <= 2'd2;
        end else begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            if (aw_valid && !aw_ready && !aw_got) begin
                if (aw_wait == 0) begin
                    aw_ready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 1;
                end
            end
            if (w_valid && !w_ready && !w_got) begin
                if (w_wait == 0) begin
                    w_ready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 1;
                end
            end
            if (aw_valid && aw_ready) begin
                aw_got  <= 1'b1;
                aw_q    <= aw_addr;
                aw_wait <= $random(seed);
            end
            if (w_valid && w_ready) begin
                w_got  <= 1'b1;
                w_q    <= w_data;
                strb_q <= w_strb;
                w_wait <= $random(seed);
            end
            if (aw_got && w_got && !b_valid) begin
                b_valid <= 1'b1;
                aw_got  <= 1'b0;
                w_got   <= 1'b0;
                if (aw_q == err_addr) begin
                    b_resp <= resp_slverr;
                end else begin
                    b_resp <= resp_okay;
                    for (int b = 0; b < 4; b++) begin
                        if (strb_q[b]) begin
                            mem[aw_q[7:2]][b*8 +: 8] <= w_q[b*8 +: 8];
                        end
                    end
                end
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== sim/tb_mem_stage.sv ====
module tb_mem_stage;

    import rv_isa_pkg::*;

    // operation kinds in the table
    localparam int k_alu = 0;
    localparam int k_csr = 1;
    localparam int k_jmp = 2;
    localparam int k_st  = 3;
    localparam int k_ld  = 4;
    localparam int k_ldf = 5;

    logic                  CLK = 1'b0;
    logic                  rst;
    logic                  flush;
    logic [reg_addr_w-1:0] exec_reg_w_rd;
    logic [xlen-1:0]       exec_reg_w_data;
    logic [csr_addr_w-1:0] exec_csr_w_addr;
    logic [xlen-1:0]       exec_csr_w_data;
    logic                  exec_mem_r_valid;
    logic [reg_addr_w-1:0] exec_mem_r_rd;
    logic [xlen-1:0]       exec_mem_r_addr;
    logic [strb_w-1:0]     exec_mem_r_strb;
    logic                  exec_mem_r_signed;
    logic                  exec_mem_w_valid;
    logic [xlen-1:0]       exec_mem_w_addr;
    logic [strb_w-1:0]     exec_mem_w_strb;
    logic [xlen-1:0]       exec_mem_w_data;
    logic                  exec_jmp_do;
    logic [xlen-1:0]       exec_jmp_pc;
    logic                  stall;
    logic                  ar_valid;
    logic                  ar_ready;
    logic [xlen-1:0]       ar_addr;
    logic                  r_valid;
    logic                  r_ready;
    logic [xlen-1:0]       r_data;
    logic [1:0]            r_resp;
    logic                  aw_valid;
    logic                  aw_ready;
    logic [xlen-1:0]       aw_addr;
    logic                  w_valid;
    logic                  w_ready;
    logic [xlen-1:0]       w_data;
    logic [strb_w-1:0]     w_strb;
    logic                  b_valid;
    logic                  b_ready;
    logic [1:0]            b_resp;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;
    logic [csr_addr_w-1:0] csr_w_addr;
    logic [xlen-1:0]       csr_w_data;
    logic                  jmp_do;
    logic [xlen-1:0]       jmp_pc;
    logic                  fault;

    int          t_kind[$];
    logic [31:0] t_addr[$];
    logic [31:0] t_data[$];
    logic [3:0]  t_strb[$];
    logic        t_sgn[$];
    logic [4:0]  t_rd[$];
    logic        t_flt[$];
    logic [31:0] shadow [64];
    int          cycles = 0;
    int          limit = 0;

    mem_stage_top mem_stage_top_i (.*);

    axi_lite_mem_model mem_model_i (.*);

    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic add(input int kind, input logic [31:0] addr, input logic [31:0] data,
                       input logic [3:0] strb, input logic sgn, input logic [4:0] rd,
                       input logic flt);
        t_kind.push_back(kind);
        t_addr.push_back(addr);
        t_data.push_back(data);
        t_strb.push_back(strb);
        t_sgn.push_back(sgn);
        t_rd.push_back(rd);
        t_flt.push_back(flt);
    endtask

    // lane pick and extension by access width
    function automatic logic [31:0] extend_lane(input logic [31:0] word, input logic [1:0] lo,
                                                input logic [3:0] strb, input logic sgn);
        logic [15:0] h;
        logic [7:0]  b;
        h = word >> (lo[1] * 16);
        b = word >> (lo * 8);
        if (strb == 4'hf) begin
            return word;
        end else if ($countones(strb) == 2) begin
            return sgn ? {{16{h[15]}}, h} : {16'h0, h};
        end
        return sgn ? {{24{b[7]}}, b} : {24'h0, b};
    endfunction

    task automatic drive_idle();
        exec_reg_w_rd = '0;
        exec_reg_w_data = '0;
        exec_csr_w_addr = '0;
        exec_csr_w_data = '0;
        exec_mem_r_valid = 1'b0;
        exec_mem_r_rd = '0;
        exec_mem_r_addr = '0;
        exec_mem_r_strb = '0;
        exec_mem_r_signed = 1'b0;
        exec_mem_w_valid = 1'b0;
        exec_mem_w_addr = '0;
        exec_mem_w_strb = '0;
        exec_mem_w_data = '0;
        exec_jmp_do = 1'b0;
        exec_jmp_pc = '0;
    endtask

    task automatic drive_entry(input int i);
        drive_idle();
        case (t_kind[i])
            k_alu: begin
                exec_reg_w_rd = t_rd[i];
                exec_reg_w_data = t_data[i];
            end
            k_csr: begin
                exec_csr_w_addr = t_addr[i][11:0];
                exec_csr_w_data = t_data[i];
            end
            k_jmp: begin
                exec_jmp_do = 1'b1;
                exec_jmp_pc = t_data[i];
            end
            k_st: begin
                exec_mem_w_valid = 1'b1;
                exec_mem_w_addr = t_addr[i];
                exec_mem_w_strb = t_strb[i];
                exec_mem_w_data = t_data[i];
            end
            default: begin
                exec_mem_r_valid = 1'b1;
                exec_mem_r_rd = t_rd[i];
                exec_mem_r_addr = t_addr[i];
                exec_mem_r_strb = t_strb[i];
                exec_mem_r_signed = t_sgn[i];
            end
        endcase
    endtask

    task automatic wait_unstalled();
        do begin
            @(negedge CLK);
        end while (stall);
    endtask

    task automatic run_entry(input int i);
        logic [31:0] exp;
        int          w;
        @(posedge CLK);
        #2;
        drive_entry(i);
        wait_unstalled();
        @(posedge CLK);
        #2;
        drive_idle();
        w = t_addr[i][7:2];
        exp = extend_lane(shadow[w], t_addr[i][1:0], t_strb[i], t_sgn[i]);
        @(negedge CLK);
        case (t_kind[i])
            k_alu: begin
                @(negedge CLK);
                check("wb_rd", wb_rd, t_rd[i]);
                if (t_rd[i] != 0) begin
                    check("wb_data", wb_data, t_data[i]);
                end
            end
            k_csr: begin
                @(negedge CLK);
                check("csr_w_addr", csr_w_addr, t_addr[i]);
                check("csr_w_data", csr_w_data, t_data[i]);
            end
            k_jmp: begin
                check("jmp_do", jmp_do, 1);
                check("jmp_pc", jmp_pc, t_data[i]);
            end
            k_ldf: begin
                check("stall", stall, 1);
                @(posedge CLK);
                #2;
                flush = 1'b1;
                @(posedge CLK);
                #2;
                flush = 1'b0;
                // flushed read still runs to its R beat
                do begin
                    @(negedge CLK);
                    check("wb_rd", wb_rd, 0);
                end while (!(r_valid && r_ready));
                repeat (2) begin
                    @(negedge CLK);
                    check("wb_rd", wb_rd, 0);
                end
            end
            default: begin
                check("stall", stall, 1);
                wait_unstalled();
                @(negedge CLK);
                check("fault", fault, t_flt[i]);
                if (t_kind[i] == k_ld) begin
                    check("wb_rd", wb_rd, t_flt[i] ? 5'd0 : t_rd[i]);
                    if (!t_flt[i]) begin
                        check("wb_data", wb_data, exp);
                    end
                end else if (!t_flt[i]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (t_strb[i][b]) begin
                            shadow[w][b*8 +: 8] = t_data[i][b*8 +: 8];
                        end
                    end
                end
                // one writeback and one fault pulse per access
                @(negedge CLK);
                check("wb_rd", wb_rd, 0);
                check("fault", fault, 0);
            end
        endcase
    endtask

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        drive_idle();
        for (int i = 0; i < 64; i++) begin
            shadow[i] = '0;
        end
        add(k_alu, 0, 32'h1234_5678, 0, 0, 5, 0);
        add(k_alu, 0, 32'h0000_dead, 0, 0, 0, 0);
        add(k_csr, 32'h300, 32'h0000_0abc, 0, 0, 0, 0);
        add(k_jmp, 0, 32'h0000_0080, 0, 0, 0, 0);
        // word store, then every width back
        add(k_st, 32'h10, 32'h8899_aabb, 4'hf, 0, 0, 0);
        add(k_ld, 32'h10, 0, 4'hf, 1, 6, 0);
        add(k_ld, 32'h10, 0, 4'h3, 1, 7, 0);
        add(k_ld, 32'h12, 0, 4'hc, 0, 8, 0);
        add(k_ld, 32'h11, 0, 4'h2, 1, 9, 0);
        add(k_ld, 32'h13, 0, 4'h8, 0, 10, 0);
        add(k_st, 32'h12, 32'hf00d_0000, 4'hc, 0, 0, 0);
        add(k_ld, 32'h12, 0, 4'hc, 1, 11, 0);
        add(k_ld, 32'h12, 0, 4'hc, 0, 12, 0);
        add(k_ld, 32'h10, 0, 4'hf, 1, 20, 0);
        add(k_ld, 32'h13, 0, 4'h8, 1, 21, 0);
        add(k_ld, 32'h12, 0, 4'h4, 0, 22, 0);
        add(k_st, 32'h11, 32'h0000_9c00, 4'h2, 0, 0, 0);
        add(k_ld, 32'h11, 0, 4'h2, 1, 13, 0);
        add(k_ld, 32'h11, 0, 4'h2, 0, 23, 0);
        add(k_ld, 32'h10, 0, 4'h3, 1, 24, 0);
        add(k_ld, 32'h10, 0, 4'h3, 0, 25, 0);
        add(k_ld, 32'h10, 0, 4'hf, 0, 14, 0);
        add(k_st, 32'h20, 32'h0102_8384, 4'hf, 0, 0, 0);
        add(k_ld, 32'h20, 0, 4'h1, 1, 15, 0);
        add(k_ld, 32'h22, 0, 4'hc, 1, 16, 0);
        add(k_ldf, 32'h10, 0, 4'hf, 0, 17, 0);
        add(k_ld, 32'h20, 0, 4'hf, 0, 18, 0);
        add(k_ld, 32'hf0, 0, 4'hf, 0, 19, 1);
        add(k_st, 32'hf0, 32'h5555_5555, 4'hf, 0, 0, 1);
        add(k_alu, 0, 32'hcafe_f00d, 0, 0, 31, 0);
        limit = t_kind.size() * 20 + 8;
        repeat (8) @(posedge CLK);
        #2;
        rst = 1'b0;
        @(negedge CLK);
        check("ar_valid", ar_valid, 0);
        check("aw_valid", aw_valid, 0);
        check("w_valid", w_valid, 0);
        check("stall", stall, 0);
        check("jmp_do", jmp_do, 0);
        check("fault", fault, 0);
        check("r_ready", r_ready, 1);
        check("b_ready", b_ready, 1);
        for (int i = 0; i < t_kind.size(); i++) begin
            run_entry(i);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== source/axi_lite_pkg.sv ====
package axi_lite_pkg;

    localparam int axi_addr_w = 32;
    localparam int axi_data_w = 32;
    localparam int axi_resp_w = 2;

    // bresp / rresp codes
    localparam logic [axi_resp_w-1:0] resp_okay   = 2'b00;
    localparam logic [axi_resp_w-1:0] resp_slverr = 2'b10;

    // phases of a single-beat master transaction
    localparam int txn_state_w = 2;
    localparam logic [txn_state_w-1:0] txn_idle = 2'd0;
    localparam logic [txn_state_w-1:0] txn_addr = 2'd1;
    localparam logic [txn_state_w-1:0] txn_resp = 2'd2;
    localparam logic [txn_state_w-1:0] txn_done = 2'd3;

endpackage

// ==== source/cushion.sv ====
module cushion (
    input  logic                              CLK,
    input  logic                              rst,
    input  logic                              flush,
    input  logic                              stall,

    input  logic [rv_isa_pkg::reg_addr_w-1:0] exec_reg_w_rd,
    input  logic [rv_isa_pkg::xlen-1:0]       exec_reg_w_data,
    input  logic [rv_isa_pkg::csr_addr_w-1:0] exec_csr_w_addr,
    input  logic [rv_isa_pkg::xlen-1:0]       exec_csr_w_data,
    input  logic                              exec_mem_r_valid,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] exec_mem_r_rd,
    input  logic [rv_isa_pkg::xlen-1:0]       exec_mem_r_addr,
    input  logic [rv_isa_pkg::strb_w-1:0]     exec_mem_r_strb,
    input  logic                              exec_mem_r_signed,
    input  logic                              exec_mem_w_valid,
    input  logic [rv_isa_pkg::xlen-1:0]       exec_mem_w_addr,
    input  logic [rv_isa_pkg::strb_w-1:0]     exec_mem_w_strb,
    input  logic [rv_isa_pkg::xlen-1:0]       exec_mem_w_data,
    input  logic                              exec_jmp_do,
    input  logic [rv_isa_pkg::xlen-1:0]       exec_jmp_pc,

    output logic [rv_isa_pkg::reg_addr_w-1:0] cush_reg_w_rd,
    output logic [rv_isa_pkg::xlen-1:0]       cush_reg_w_data,
    output logic [rv_isa_pkg::csr_addr_w-1:0] cush_csr_w_addr,
    output logic [rv_isa_pkg::xlen-1:0]       cush_csr_w_data,
    output logic                              cush_mem_r_valid,
    output logic [rv_isa_pkg::reg_addr_w-1:0] cush_mem_r_rd,
    output logic [rv_isa_pkg::xlen-1:0]       cush_mem_r_addr,
    output logic [rv_isa_pkg::strb_w-1:0]     cush_mem_r_strb,
    output logic                              cush_mem_r_signed,
    output logic                              cush_mem_w_valid,
    output logic [rv_isa_pkg::xlen-1:0]       cush_mem_w_addr,
    output logic [rv_isa_pkg::strb_w-1:0]     cush_mem_w_strb,
    output logic [rv_isa_pkg::xlen-1:0]       cush_mem_w_data,
    output logic                              cush_jmp_do,
    output logic [rv_isa_pkg::xlen-1:0]       cush_jmp_pc
);

    // flush wins over stall, so a held access is dropped too
    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            cush_reg_w_rd     <= '0;
            cush_reg_w_data   <= '0;
            cush_csr_w_addr   <= '0;
            cush_csr_w_data   <= '0;
            cush_mem_r_valid  <= 1'b0;
            cush_mem_r_rd     <= '0;
            cush_mem_r_addr   <= '0;
            cush_mem_r_strb   <= '0;
            cush_mem_r_signed <= 1'b0;
            cush_mem_w_valid  <= 1'b0;
            cush_mem_w_addr   <= '0;
            cush_mem_w_strb   <= '0;
            cush_mem_w_data   <= '0;
            cush_jmp_do       <= 1'b0;
            cush_jmp_pc       <= '0;
        end else if (!stall) begin
            cush_reg_w_rd     <= exec_reg_w_rd;
            cush_reg_w_data   <= exec_reg_w_data;
            cush_csr_w_addr   <= exec_csr_w_addr;
            cush_csr_w_data   <= exec_csr_w_data;
            cush_mem_r_valid  <= exec_mem_r_valid;
            cush_mem_r_rd     <= exec_mem_r_rd;
            cush_mem_r_addr   <= exec_mem_r_addr;
            cush_mem_r_strb   <= exec_mem_r_strb;
            cush_mem_r_signed <= exec_mem_r_signed;
            cush_mem_w_valid  <= exec_mem_w_valid;
            cush_mem_w_addr   <= exec_mem_w_addr;
            cush_mem_w_strb   <= exec_mem_w_strb;
            cush_mem_w_data   <= exec_mem_w_data;
            cush_jmp_do       <= exec_jmp_do;
            cush_jmp_pc       <= exec_jmp_pc;
        end
    end

endmodule

// ==== source/load_unit.sv ====
module load_unit (
    input  logic                                CLK,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                cush_mem_r_valid,
    input  logic [rv_isa_pkg::reg_addr_w-1:0]   cush_mem_r_rd,
    input  logic [rv_isa_pkg::xlen-1:0]         cush_mem_r_addr,
    input  logic [rv_isa_pkg::strb_w-1:0]       cush_mem_r_strb,
    input  logic                                cush_mem_r_signed,
    input  logic                                ar_ready,
    input  logic                                r_valid,
    input  logic [axi_lite_pkg::axi_data_w-1:0] r_data,
    input  logic [axi_lite_pkg::axi_resp_w-1:0] r_resp,
    output logic                                ar_valid,
    output logic [axi_lite_pkg::axi_addr_w-1:0] ar_addr,
    output logic                                r_ready,
    output logic                                load_done,
    output logic [rv_isa_pkg::reg_addr_w-1:0]   load_rd,
    output logic [rv_isa_pkg::xlen-1:0]         load_data,
    output logic                                load_err
);

    import rv_isa_pkg::*;
    import axi_lite_pkg::*;

    logic [txn_state_w-1:0] state;
    logic                   squash;
    logic                   start;
    logic                   sign_q;
    logic [strb_w-1:0]      strb_q;
    logic [1:0]             lane_q;
    load_word_t             word_q;
    logic [7:0]             sel_byte;
    logic [15:0]            sel_half;

    assign start = (state == txn_idle) && cush_mem_r_valid;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state  <= txn_idle;
            squash <= 1'b0;
        end else begin
            case (state)
                txn_idle: begin
                    if (cush_mem_r_valid) begin
                        state  <= txn_addr;
                        squash <= flush;
                    end
                end
                txn_addr: begin
                    if (ar_ready) begin
                        state <= txn_resp;
                    end
                    if (flush) begin
                        squash <= 1'b1;
                    end
                end
                txn_resp: begin
                    if (r_valid) begin
                        state <= txn_done;
                    end
                    if (flush) begin
                        squash <= 1'b1;
                    end
                end
                default: state <= txn_idle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            ar_addr <= {cush_mem_r_addr[xlen-1:2], 2'b00};
            load_rd <= cush_mem_r_rd;
            sign_q  <= cush_mem_r_signed;
            strb_q  <= cush_mem_r_strb;
            lane_q  <= cush_mem_r_addr[1:0];
        end
        if (state == txn_resp && r_valid) begin
            word_q   <= r_data;
            load_err <= (r_resp == resp_slverr);
        end
    end

    // access width follows the number of enabled lanes
    always_comb begin
        sel_byte = word_q.bytes[lane_q];
        sel_half = word_q.halves[lane_q[1]];
        if ($countones(strb_q) == strb_w) begin
            load_data = word_q;
        end else if ($countones(strb_q) == 2) begin
            load_data = {{16{sign_q & sel_half[15]}}, sel_half};
        end else begin
            load_data = {{24{sign_q & sel_byte[7]}}, sel_byte};
        end
    end

    assign ar_valid  = (state == txn_addr);
    assign r_ready   = 1'b1;
    assign load_done = (state == txn_done) && !squash;

endmodule

// ==== source/mem_stage_top.sv ====
module mem_stage_top (
    input  logic                                CLK,
    input  logic                                rst,
    input  logic                                flush,

    input  logic [rv_isa_pkg::reg_addr_w-1:0]   exec_reg_w_rd,
    input  logic [rv_isa_pkg::xlen-1:0]         exec_reg_w_data,
    input  logic [rv_isa_pkg::csr_addr_w-1:0]   exec_csr_w_addr,
    input  logic [rv_isa_pkg::xlen-1:0]         exec_csr_w_data,
    input  logic                                exec_mem_r_valid,
    input  logic [rv_isa_pkg::reg_addr_w-1:0]   exec_mem_r_rd,
    input  logic [rv_isa_pkg::xlen-1:0]         exec_mem_r_addr,
    input  logic [rv_isa_pkg::strb_w-1:0]       exec_mem_r_strb,
    input  logic                                exec_mem_r_signed,
    input  logic                                exec_mem_w_valid,
    input  logic [rv_isa_pkg::xlen-1:0]         exec_mem_w_addr,
    input  logic [rv_isa_pkg::strb_w-1:0]       exec_mem_w_strb,
    input  logic [rv_isa_pkg::xlen-1:0]         exec_mem_w_data,
    input  logic                                exec_jmp_do,
    input  logic [rv_isa_pkg::xlen-1:0]         exec_jmp_pc,
    output logic                                stall,

    output logic                                ar_valid,
    input  logic                                ar_ready,
    output logic [axi_lite_pkg::axi_addr_w-1:0] ar_addr,
    input  logic                                r_valid,
    output logic                                r_ready,
    input  logic [axi_lite_pkg::axi_data_w-1:0] r_data,
    input  logic [axi_lite_pkg::axi_resp_w-1:0] r_resp,
    output logic                                aw_valid,
    input  logic                                aw_ready,
    output logic [axi_lite_pkg::axi_addr_w-1:0] aw_addr,
    output logic                                w_valid,
    input  logic                                w_ready,
    output logic [axi_lite_pkg::axi_data_w-1:0] w_data,
    output logic [rv_isa_pkg::strb_w-1:0]       w_strb,
    input  logic                                b_valid,
    output logic                                b_ready,
    input  logic [axi_lite_pkg::axi_resp_w-1:0] b_resp,

    output logic [rv_isa_pkg::reg_addr_w-1:0]   wb_rd,
    output logic [rv_isa_pkg::xlen-1:0]         wb_data,
    output logic [rv_isa_pkg::csr_addr_w-1:0]   csr_w_addr,
    output logic [rv_isa_pkg::xlen-1:0]         csr_w_data,
    output logic                                jmp_do,
    output logic [rv_isa_pkg::xlen-1:0]         jmp_pc,
    output logic                                fault
);

    import rv_isa_pkg::*;

    logic [reg_addr_w-1:0] cush_reg_w_rd;
    logic [xlen-1:0]       cush_reg_w_data;
    logic [csr_addr_w-1:0] cush_csr_w_addr;
    logic [xlen-1:0]       cush_csr_w_data;
    logic                  cush_mem_r_valid;
    logic [reg_addr_w-1:0] cush_mem_r_rd;
    logic [xlen-1:0]       cush_mem_r_addr;
    logic [strb_w-1:0]     cush_mem_r_strb;
    logic                  cush_mem_r_signed;
    logic                  cush_mem_w_valid;
    logic [xlen-1:0]       cush_mem_w_addr;
    logic [strb_w-1:0]     cush_mem_w_strb;
    logic [xlen-1:0]       cush_mem_w_data;
    logic                  cush_jmp_do;
    logic [xlen-1:0]       cush_jmp_pc;

    logic                  load_done;
    logic [reg_addr_w-1:0] load_rd;
    logic [xlen-1:0]       load_data;
    logic                  load_err;
    logic                  store_done;
    logic                  store_err;

    // held access not finished yet, so execute must wait
    assign stall = (cush_mem_r_valid && !load_done) || (cush_mem_w_valid && !store_done);

    assign jmp_do = cush_jmp_do;
    assign jmp_pc = cush_jmp_pc;

    // port names match the nets one to one
    cushion cushion_i (.*);

    load_unit load_unit_i (.*);

    store_unit store_unit_i (.*);

    writeback_merge writeback_merge_i (.*);

endmodule

// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // data path and address width
    localparam int xlen = 32;

    // integer register index
    localparam int reg_addr_w = 5;

    // csr address space
    localparam int csr_addr_w = 12;

    // byte lanes per data word
    localparam int strb_w = xlen / 8;

    // one read word picked apart by byte or by halfword
    typedef union packed {
        logic [strb_w-1:0][7:0]    bytes;
        logic [strb_w/2-1:0][15:0] halves;
    } load_word_t;

endpackage

// ==== source/store_unit.sv ====
module store_unit (
    input  logic                                CLK,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                cush_mem_w_valid,
    input  logic [rv_isa_pkg::xlen-1:0]         cush_mem_w_addr,
    input  logic [rv_isa_pkg::strb_w-1:0]       cush_mem_w_strb,
    input  logic [rv_isa_pkg::xlen-1:0]         cush_mem_w_data,
    input  logic                                aw_ready,
    input  logic                                w_ready,
    input  logic                                b_valid,
    input  logic [axi_lite_pkg::axi_resp_w-1:0] b_resp,
    output logic                                aw_valid,
    output logic [axi_lite_pkg::axi_addr_w-1:0] aw_addr,
    output logic                                w_valid,
    output logic [axi_lite_pkg::axi_data_w-1:0] w_data,
    output logic [rv_isa_pkg::strb_w-1:0]       w_strb,
    output logic                                b_ready,
    output logic                                store_done,
    output logic                                store_err
);

    import axi_lite_pkg::*;

    logic [txn_state_w-1:0] state;
    logic                   squash;
    logic                   aw_wait;
    logic                   w_wait;

    // channel still open after this cycle
    assign aw_wait = aw_valid && !aw_ready;
    assign w_wait  = w_valid && !w_ready;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state    <= txn_idle;
            squash   <= 1'b0;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
        end else begin
            case (state)
                txn_idle: begin
                    if (cush_mem_w_valid) begin
                        state    <= txn_addr;
                        squash   <= flush;
                        aw_valid <= 1'b1;
                        w_valid  <= 1'b1;
                    end
                end
                txn_addr: begin
                    aw_valid <= aw_wait;
                    w_valid  <= w_wait;
                    if (!aw_wait && !w_wait) begin
                        state <= txn_resp;
                    end
                    if (flush) begin
                        squash <= 1'b1;
                    end
                end
                txn_resp: begin
                    if (b_valid) begin
                        state <= txn_done;
                    end
                    if (flush) begin
                        squash <= 1'b1;
                    end
                end
                default: state <= txn_idle;
            endcase
        end
    end

    // data and strobes arrive lane-placed from execute
    always_ff @(posedge CLK) begin
        if (state == txn_idle && cush_mem_w_valid) begin
            aw_addr <= {cush_mem_w_addr[31:2], 2'b00};
            w_data  <= cush_mem_w_data;
            w_strb  <= cush_mem_w_strb;
        end
        if (state == txn_resp && b_valid) begin
            store_err <= (b_resp == resp_slverr);
        end
    end

    assign b_ready    = 1'b1;
    assign store_done = (state == txn_done) && !squash;

endmodule

// ==== source/writeback_merge.sv ====
module writeback_merge (
    input  logic                              CLK,
    input  logic                              rst,
    input  logic                              stall,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] cush_reg_w_rd,
    input  logic [rv_isa_pkg::xlen-1:0]       cush_reg_w_data,
    input  logic [rv_isa_pkg::csr_addr_w-1:0] cush_csr_w_addr,
    input  logic [rv_isa_pkg::xlen-1:0]       cush_csr_w_data,
    input  logic                              load_done,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] load_rd,
    input  logic [rv_isa_pkg::xlen-1:0]       load_data,
    input  logic                              load_err,
    input  logic                              store_done,
    input  logic                              store_err,
    output logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_isa_pkg::xlen-1:0]       wb_data,
    output logic [rv_isa_pkg::csr_addr_w-1:0] csr_w_addr,
    output logic [rv_isa_pkg::xlen-1:0]       csr_w_data,
    output logic                              fault
);

    always_ff @(posedge CLK) begin
        if (rst) begin
            wb_rd      <= '0;
            wb_data    <= '0;
            csr_w_addr <= '0;
            csr_w_data <= '0;
            fault      <= 1'b0;
        end else begin
            // a faulted load never reaches the register file
            if (load_done && !load_err) begin
                wb_rd   <= load_rd;
                wb_data <= load_data;
            end else if (!stall && cush_reg_w_rd != '0) begin
                wb_rd   <= cush_reg_w_rd;
                wb_data <= cush_reg_w_data;
            end else begin
                wb_rd <= '0;
            end
            if (!stall && cush_csr_w_addr != '0) begin
                csr_w_addr <= cush_csr_w_addr;
                csr_w_data <= cush_csr_w_data;
            end else begin
                csr_w_addr <= '0;
            end
            fault <= (load_done && load_err) || (store_done && store_err);
        end
    end

endmodule
